/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_params.svh"

module aluUnit (
  input  execCore_pkg::execCtrl_s execCtrl,  // Registered decode result
  input  logic [`EXEC_DATA_W-1:0] rdData1,   // rs, or old rd for byte loads
  input  logic [`EXEC_DATA_W-1:0] rdData2,   // rt
  output execCore_pkg::wbBus_s    wb
);

  logic [`EXEC_DATA_W-1:0] result;  // ALU output before the bus
  logic [3:0]              shAmt;   // Shift amount, 0 to 15

  assign shAmt = rdData2[3:0];

  //////////////////////////////
  // Operation select
  //////////////////////////////

  always_comb begin
    result = '0;
    case (execCtrl.op)
      execCore_pkg::ADD: result = rdData1 + rdData2;  // Carry out dropped
      execCore_pkg::SUB: result = rdData1 - rdData2;
      execCore_pkg::AND: result = rdData1 & rdData2;
      execCore_pkg::OR:  result = rdData1 | rdData2;
      execCore_pkg::XOR: result = rdData1 ^ rdData2;
      execCore_pkg::SLL: result = rdData1 << shAmt;   // Zero fill
      execCore_pkg::SRL: result = rdData1 >> shAmt;   // Logical, zero fill
      execCore_pkg::LLB: begin
        result = {rdData1[`EXEC_DATA_W-1:`EXEC_IMM_W], execCtrl.imm8};  // Keep high byte
      end
      execCore_pkg::LHB: begin
        result = {execCtrl.imm8, rdData1[`EXEC_IMM_W-1:0]};  // Keep low byte
      end
      default: result = '0;  // No-op codes, valid already low
    endcase
  end

  //////////////////////////////
  // Write-back bus
  //////////////////////////////

  // Valid and destination pass straight through
  assign wb.valid  = execCtrl.valid;
  assign wb.dstReg = execCtrl.dstReg;
  assign wb.data   = result;

endmodule

`default_nettype wire

/* execCore.f */
+incdir+.
execCore_pkg.sv
regFile.sv
instrDecode.sv
aluUnit.sv
execCore.sv
execCore_assert.sv
execCore_tb.sv

/* execCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_params.svh"

module execCore (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instrValid,  // Never stalled
  input  execCore_pkg::instrWord_u instrWord,
  output execCore_pkg::wbBus_s     wb           // Result one cycle after the strobe edge
);

  logic [`EXEC_REG_AW-1:0] rdAddr1;   // Decode to register file
  logic [`EXEC_REG_AW-1:0] rdAddr2;
  logic [`EXEC_DATA_W-1:0] rdData1;   // Register file to ALU
  logic [`EXEC_DATA_W-1:0] rdData2;
  execCore_pkg::execCtrl_s execCtrl;  // Decode to ALU

  //////////////////////////////
  // Decode, edge E0
  //////////////////////////////

  instrDecode instrDecode_inst (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instrWord  (instrWord),
    .rdAddr1    (rdAddr1),
    .rdAddr2    (rdAddr2),
    .execCtrl   (execCtrl)
  );

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Read at E0, write-back at E1
  regFile regFile_inst (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (rdAddr1),
    .rdAddr2 (rdAddr2),
    .wr      (wb),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  aluUnit aluUnit_inst (
    .execCtrl (execCtrl),
    .rdData1  (rdData1),
    .rdData2  (rdData2),
    .wb       (wb)  // Also feeds the write port
  );

endmodule

`default_nettype wire

/* execCore_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore_assert (
  input logic                 clk,
  input logic                 rst,
  input logic                 instrValid,
  input execCore_pkg::wbBus_s wb
);

  // Quiet bus right after each reset edge
  resetQuiet: assert property (@(posedge clk) rst |=> !wb.valid)
    else $error("wb.valid high in the cycle after a reset edge");

  // A result needs a strobe one cycle earlier
  strobeCause: assert property (@(posedge clk) disable iff (rst)
    wb.valid |-> $past(instrValid))
    else $error("wb.valid high without a strobe one cycle earlier");

  // Destination and data known while valid
  wbKnown: assert property (@(posedge clk) disable iff (rst)
    wb.valid |-> !$isunknown({wb.dstReg, wb.data}))
    else $error("wb.dstReg or wb.data unknown while wb.valid is high");

endmodule

bind execCore execCore_assert execCore_assert_inst (
  .clk        (clk),
  .rst        (rst),
  .instrValid (instrValid),
  .wb         (wb)
);

`default_nettype wire

/* execCore_params.svh */
`ifndef EXEC_CORE_PARAMS_SVH
`define EXEC_CORE_PARAMS_SVH

//////////////////////////////
// Core widths
//////////////////////////////

// Data path and instruction word width
`define EXEC_DATA_W 16

// Architectural registers, r0 reads as zero
`define EXEC_REG_CNT 16

// Register address width, enough for EXEC_REG_CNT entries
`define EXEC_REG_AW 4

// Immediate field of the byte loads
`define EXEC_IMM_W 8

`endif

/* execCore_pkg.sv */
`default_nettype none

`include "execCore_params.svh"

package execCore_pkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [3:0] {
    ADD = 4'd0,  // Wraps at data width
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,  // Amount from low 4 bits of rt
    SRL = 4'd6,
    LLB = 4'd8,  // Low byte of rd from imm8
    LHB = 4'd9   // High byte of rd from imm8
  } aluOp_e;     // Remaining codes are no-ops

  //////////////////////////////
  // Instruction formats
  //////////////////////////////

  typedef struct packed {
    aluOp_e                  opcode;
    logic [`EXEC_REG_AW-1:0] rd;
    logic [`EXEC_REG_AW-1:0] rs;
    logic [`EXEC_REG_AW-1:0] rt;
  } rType_s;

  typedef struct packed {
    aluOp_e                  opcode;
    logic [`EXEC_REG_AW-1:0] rd;
    logic [`EXEC_IMM_W-1:0]  imm8;
  } iType_s;

  // Same word, view picked by opcode
  typedef union packed {
    rType_s rType;
    iType_s iType;
  } instrWord_u;

  //////////////////////////////
  // Pipeline buses
  //////////////////////////////

  typedef struct packed {
    logic                    valid;   // Writing instruction in execute
    aluOp_e                  op;
    logic [`EXEC_REG_AW-1:0] dstReg;
    logic [`EXEC_IMM_W-1:0]  imm8;
  } execCtrl_s;

  typedef struct packed {
    logic                    valid;   // Result to be written this cycle
    logic [`EXEC_REG_AW-1:0] dstReg;
    logic [`EXEC_DATA_W-1:0] data;
  } wbBus_s;

endpackage

`default_nettype wire

/* execCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_params.svh"

module execCore_tb;

  localparam int ClkPeriod   = 40;
  localparam int NumRandom   = 2000;
  localparam int MaxGap      = 3;    // Longest idle run between random strobes
  localparam int DirectedCyc = 300;  // Upper bound for the directed part
  localparam int MarginCyc   = 100;
  localparam int TimeoutNs   = ClkPeriod * (NumRandom * (MaxGap + 1) + DirectedCyc + MarginCyc);

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     instrValid;
  execCore_pkg::instrWord_u instrWord;
  execCore_pkg::wbBus_s     wb;

  logic [`EXEC_DATA_W-1:0] model [`EXEC_REG_CNT];  // Expected register contents
  execCore_pkg::wbBus_s    expQ [$];               // One entry per strobe, oldest first
  int                      idxQ [$];               // Strobe numbers for messages
  execCore_pkg::wbBus_s    lastExp;                // Prediction for the latest strobe
  execCore_pkg::wbBus_s    curExp;                 // Entry under check
  int                      curIdx;
  logic                    strobeSeen;             // Strobe sampled at the last rising edge
  logic [31:0]             rngState   = 32'd80794;
  int                      numIssued  = 0;
  int                      numChecked = 0;

  execCore execCore_inst (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instrWord  (instrWord),
    .wb         (wb)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic execCore_pkg::instrWord_u rInstr(input logic [3:0] op, input logic [3:0] rd,
                                                      input logic [3:0] rs, input logic [3:0] rt);
    return execCore_pkg::instrWord_u'({op, rd, rs, rt});
  endfunction

  function automatic execCore_pkg::instrWord_u iInstr(input logic [3:0] op, input logic [3:0] rd,
                                                      input logic [7:0] imm);
    return execCore_pkg::instrWord_u'({op, rd, imm});
  endfunction

  // Known constant for register i
  function automatic logic [15:0] constFor(input int i);
    return 16'((i * 32'h1357) ^ 32'hA50F);
  endfunction

  // Applies one instruction to the model, returns the expected bus
  function automatic execCore_pkg::wbBus_s refExec(input execCore_pkg::instrWord_u w);
    execCore_pkg::wbBus_s res;
    logic [15:0] raw;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    raw = w;
    op  = raw[15:12];
    rd  = raw[11:8];
    a   = model[raw[7:4]];  // rs
    b   = model[raw[3:0]];  // rt
    res.valid  = 1'b1;
    res.dstReg = rd;
    res.data   = '0;
    case (op)
      4'd0: res.data = a + b;
      4'd1: res.data = a - b;
      4'd2: res.data = a & b;
      4'd3: res.data = a | b;
      4'd4: res.data = a ^ b;
      4'd5: res.data = a << b[3:0];
      4'd6: res.data = a >> b[3:0];
      4'd8: res.data = {model[rd][15:8], raw[7:0]};  // LLB
      4'd9: res.data = {raw[7:0], model[rd][7:0]};   // LHB
      default: res.valid = 1'b0;                     // No-op
    endcase
    if (res.valid && (rd != 4'd0)) begin
      model[rd] = res.data;  // r0 stays zero
    end
    return res;
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] expected, input string what);
    if (got !== expected) begin
      $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
      $display("Testbench failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic sendInstr(input execCore_pkg::instrWord_u w);
    @(negedge clk);
    instrValid = 1'b1;
    instrWord  = w;
    lastExp    = refExec(w);
    expQ.push_back(lastExp);
    idxQ.push_back(numIssued);
    numIssued++;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      rngState   = xorshift32(rngState);
      instrValid = 1'b0;
      instrWord  = execCore_pkg::instrWord_u'(rngState[15:0]);  // Junk, no strobe
    end
  endtask

  //////////////////////////////
  // Directed sections
  //////////////////////////////

  task automatic resetReads();
    sendInstr(rInstr(4'd0, 4'd1, 4'd2, 4'd3));    // ADD r1, r2, r3
    sendInstr(rInstr(4'd1, 4'd4, 4'd5, 4'd6));    // SUB r4, r5, r6
    sendInstr(rInstr(4'd6, 4'd7, 4'd15, 4'd8));   // SRL r7, r15, r8
    idleCycles(2);
  endtask

  task automatic buildConstants();
    logic [15:0] c;
    for (int i = 1; i < `EXEC_REG_CNT; i++) begin
      c = constFor(i);
      sendInstr(iInstr(4'd8, 4'(i), c[7:0]));     // LLB
      sendInstr(iInstr(4'd9, 4'(i), c[15:8]));    // LHB reads rd through the bypass
    end
    idleCycles(2);
    for (int i = 1; i < `EXEC_REG_CNT; i++) begin
      sendInstr(rInstr(4'd0, 4'(i), 4'(i), 4'd0));  // ADD ri, ri, r0
      checkEq(32'(lastExp.data), 32'(constFor(i)), $sformatf("constant in r%0d", i));
    end
    idleCycles(2);
  endtask

  task automatic zeroRegWrites();
    sendInstr(iInstr(4'd8, 4'd0, 8'h5A));         // LLB r0 is dropped
    sendInstr(iInstr(4'd9, 4'd0, 8'hC3));
    sendInstr(rInstr(4'd3, 4'd5, 4'd0, 4'd0));    // OR r5, r0, r0
    checkEq(32'(lastExp.data), 32'd0, "r0 read after writes");
    idleCycles(2);
  endtask

  task automatic bypassChain();
    sendInstr(iInstr(4'd8, 4'd1, 8'h03));
    sendInstr(iInstr(4'd9, 4'd1, 8'h00));
    for (int k = 1; k <= 10; k++) begin
      sendInstr(rInstr(4'd0, 4'd1, 4'd1, 4'd1));  // Doubles r1 every cycle
      checkEq(32'(lastExp.data), 32'(16'h3 << k), "doubling chain");
    end
    idleCycles(2);
  endtask

  task automatic opcodeSweep();
    sendInstr(iInstr(4'd8, 4'd2, 8'h21));         // r2 = 0x8421
    sendInstr(iInstr(4'd9, 4'd2, 8'h84));
    sendInstr(iInstr(4'd8, 4'd3, 8'hF5));         // r3 = 0x00F5, shift by 5
    sendInstr(iInstr(4'd9, 4'd3, 8'h00));
    for (int op = 0; op < 16; op++) begin
      sendInstr(rInstr(4'(op), 4'd4, 4'd2, 4'd3));
    end
    for (int op = 0; op < 16; op++) begin
      sendInstr(rInstr(4'(op), 4'd6, 4'd3, 4'd2));  // Swapped, shift by 1
    end
    idleCycles(2);
  endtask

  task automatic randomStream();
    logic [1:0] gap;
    for (int n = 0; n < NumRandom; n++) begin
      rngState = xorshift32(rngState);
      gap      = rngState[20] ? rngState[17:16] : 2'd0;  // Mostly back to back
      sendInstr(execCore_pkg::instrWord_u'(rngState[15:0]));
      if (gap != 2'd0) begin
        idleCycles(int'(gap));
      end
    end
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always begin
    @(posedge clk);
    strobeSeen = instrValid && !rst;  // Inputs change on the falling edge only
    @(negedge clk);                   // wb is stable mid-cycle
    if (strobeSeen) begin
      checkEq(32'(expQ.size() != 0), 32'd1, "expectation queued for a strobe");
      curExp = expQ.pop_front();
      curIdx = idxQ.pop_front();
      checkEq(32'(wb.valid), 32'(curExp.valid), $sformatf("wb.valid of strobe %0d", curIdx));
      if (curExp.valid) begin
        checkEq(32'(wb.dstReg), 32'(curExp.dstReg), $sformatf("wb.dstReg of strobe %0d", curIdx));
        checkEq(32'(wb.data), 32'(curExp.data), $sformatf("wb.data of strobe %0d", curIdx));
      end
      numChecked++;
    end else begin
      checkEq(32'(wb.valid), 32'd0, "wb.valid without a strobe");
    end
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not complete within %0d ns", TimeoutNs);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instrWord  = '0;
    for (int r = 0; r < `EXEC_REG_CNT; r++) begin
      model[r] = '0;  // Matches the cleared register file
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    resetReads();
    buildConstants();
    zeroRegWrites();
    bypassChain();
    opcodeSweep();
    randomStream();

    idleCycles(3);
    while (expQ.size() != 0) begin
      @(negedge clk);  // Drain the last results
    end
    checkEq(32'(numChecked), 32'(numIssued), "number of checked strobes");
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_params.svh"

module instrDecode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instrValid,  // One-cycle strobe per instruction
  input  execCore_pkg::instrWord_u instrWord,
  output logic [`EXEC_REG_AW-1:0]  rdAddr1,     // Combinational, to regFile
  output logic [`EXEC_REG_AW-1:0]  rdAddr2,
  output execCore_pkg::execCtrl_s  execCtrl     // One cycle later, to the ALU
);

  execCore_pkg::aluOp_e opcode;  // Same position in both views
  logic                 isImm;   // Byte load, I-type view

  // Opcodes that produce a write-back
  function automatic logic writesReg(input execCore_pkg::aluOp_e op);
    case (op)
      execCore_pkg::ADD, execCore_pkg::SUB, execCore_pkg::AND,
      execCore_pkg::OR,  execCore_pkg::XOR, execCore_pkg::SLL,
      execCore_pkg::SRL, execCore_pkg::LLB, execCore_pkg::LHB: return 1'b1;
      default:                                                  return 1'b0;
    endcase
  endfunction

  assign opcode = instrWord.rType.opcode;
  assign isImm  = (opcode == execCore_pkg::LLB) || (opcode == execCore_pkg::LHB);

  //////////////////////////////
  // Read addresses
  //////////////////////////////

  // Byte loads read the old rd to merge into
  assign rdAddr1 = isImm ? instrWord.iType.rd : instrWord.rType.rs;
  assign rdAddr2 = instrWord.rType.rt;  // Ignored by the ALU for I-type

  //////////////////////////////
  // Execute control register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      execCtrl.valid <= 1'b0;
    end else begin
      execCtrl.valid <= instrValid && writesReg(opcode);  // No-ops never write
    end
  end

  // Payload follows the strobe only
  always_ff @(posedge clk) begin
    if (instrValid) begin
      execCtrl.op     <= opcode;
      execCtrl.dstReg <= instrWord.rType.rd;  // Same bits in both views
      execCtrl.imm8   <= instrWord.iType.imm8;
    end
  end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_params.svh"

module regFile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`EXEC_REG_AW-1:0] rdAddr1,  // Sampled at the clock edge
  input  logic [`EXEC_REG_AW-1:0] rdAddr2,
  input  execCore_pkg::wbBus_s    wr,       // Write-back from the ALU
  output logic [`EXEC_DATA_W-1:0] rdData1,  // Valid one cycle after the address
  output logic [`EXEC_DATA_W-1:0] rdData2
);

  logic [`EXEC_DATA_W-1:0] regs [`EXEC_REG_CNT];  // Register array, regs[0] stays zero
  logic                    wrEn;                  // Qualified write strobe

  // Writes to r0 are dropped here
  assign wrEn = wr.valid && (wr.dstReg != '0);

  // Next read value for one port, write-first
  function automatic logic [`EXEC_DATA_W-1:0] readPort(input logic [`EXEC_REG_AW-1:0] addr);
    logic [`EXEC_DATA_W-1:0] val;
    val = regs[addr];
    if (wrEn && (wr.dstReg == addr)) begin
      val = wr.data;  // Same-edge write wins
    end
    return val;
  endfunction

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};  // Whole file cleared
    end else if (wrEn) begin
      regs[wr.dstReg] <= wr.data;
    end
  end

  //////////////////////////////
  // Registered read ports
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rdData1 <= '0;
      rdData2 <= '0;
    end else begin
      rdData1 <= readPort(rdAddr1);  // Bypass covers back-to-back dependency
      rdData2 <= readPort(rdAddr2);
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the execCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module execCore_tb \
  -f execCore.f \
  -o execCore_sim

./obj_dir/execCore_sim
